/* src/mem_types_pkg.sv */
// memory model types
// address, block, tag and command, plus the two-view address union

`default_nettype none

package mem_types_pkg;

    // byte address as the requester drives it
    typedef logic [31:0] mem_addr_t;

    // one 64-bit data block, the unit of every transfer
    typedef logic [63:0] mem_block_t;

    // transaction tag, 0 is none or refused
    typedef logic [3:0] mem_tag_t;

    // requester command levels
    typedef enum logic [1:0] {
        MEM_NONE  = 2'b00,
        MEM_LOAD  = 2'b01,
        MEM_STORE = 2'b10
    } mem_cmd_e;

    // block view of an address
    typedef struct packed {
        logic [28:0] block_index;
        logic [2:0]  byte_offset;
    } mem_addr_fields_t;

    // same word, read whole for the range check
    // or split for alignment and the array index
    typedef union packed {
        mem_addr_t        byte_addr;
        mem_addr_fields_t fields;
    } mem_addr_u;

endpackage

`default_nettype wire

/* src/mem_config_pkg.sv */
// memory model sizing
// memory size, line count, tag count and latency

`default_nettype none

package mem_config_pkg;

    localparam int unsigned MEM_SIZE_IN_BYTES = 4096;

    // 64-bit lines
    localparam int unsigned MEM_LINES       = MEM_SIZE_IN_BYTES / 8;
    localparam int unsigned LINE_INDEX_BITS = $clog2(MEM_LINES);

    // tags 1 to 15, tag 0 is reserved for refused
    localparam int unsigned NUM_MEM_TAGS = 15;

    // countdown loaded on allocation
    localparam int unsigned MEM_LATENCY        = 6;
    localparam int unsigned LATENCY_COUNT_BITS = $clog2(MEM_LATENCY + 1);

endpackage

`default_nettype wire

/* src/mem_request_decode.sv */
// request decode stage
// alignment, range and command checks, load and store strobes, line index

`timescale 1ns/10ps
`default_nettype none

module mem_request_decode (
    input  wire mem_types_pkg::mem_addr_t             proc2mem_addr,
    input  wire mem_types_pkg::mem_cmd_e              proc2mem_command,
    output logic [mem_config_pkg::LINE_INDEX_BITS-1:0] line_index,
    output logic                                      do_load,
    output logic                                      do_store,
    output logic                                      accept_request
);

    import mem_types_pkg::*;
    import mem_config_pkg::*;

    mem_addr_u addr_u;
    logic      aligned;
    logic      in_range;
    logic      valid_address;

    assign addr_u = proc2mem_addr;

    // whole blocks only
    assign aligned  = (addr_u.fields.byte_offset == 3'b000);
    assign in_range = (addr_u.byte_addr < MEM_SIZE_IN_BYTES);

    assign valid_address = aligned && in_range;

    // upper block bits are zero once the range check passes
    assign line_index = addr_u.fields.block_index[LINE_INDEX_BITS-1:0];

    // qualified commands
    assign do_load  = valid_address && (proc2mem_command == MEM_LOAD);
    assign do_store = valid_address && (proc2mem_command == MEM_STORE);

    // any valid request wants a tag
    assign accept_request = do_load || do_store;

endmodule

`default_nettype wire

/* src/mem_array.sv */
// block storage array
// clocked write port, combinational read port

`timescale 1ns/10ps
`default_nettype none

module mem_array (
    input  wire logic                                     clock,
    input  wire logic [mem_config_pkg::LINE_INDEX_BITS-1:0] line_index,
    input  wire logic                                     do_store,
    input  wire mem_types_pkg::mem_block_t                write_block,
    output mem_types_pkg::mem_block_t                     read_block
);

    import mem_types_pkg::*;
    import mem_config_pkg::*;

    // one entry per 64-bit line
    mem_block_t lines [MEM_LINES];

    //////////////////////////////
    // write port
    //////////////////////////////

    // store lands at the request edge
    always_ff @(posedge clock) begin
        if (do_store) begin
            lines[line_index] <= write_block;
        end
    end

    //////////////////////////////
    // read port
    //////////////////////////////

    // asynchronous read, so a load sampled with a same-cycle
    // store to that line still sees the old contents
    assign read_block = lines[line_index];

endmodule

`default_nettype wire

/* src/mem_tag_table.sv */
// execute stage tag table
// per-tag countdown, waiting flag and captured load data
// lowest-free allocation and the registered transaction tag

`timescale 1ns/10ps
`default_nettype none

module mem_tag_table (
    input  wire logic                                    clock,
    input  wire logic                                    arst_n,
    input  wire logic                                    accept_request,
    input  wire logic                                    do_load,
    input  wire mem_types_pkg::mem_block_t               read_block,
    input  wire logic [mem_config_pkg::NUM_MEM_TAGS:1]   grant_vector,
    output mem_types_pkg::mem_tag_t                      transaction_tag,
    output logic [mem_config_pkg::NUM_MEM_TAGS:1]        ready_vector,
    output mem_types_pkg::mem_block_t                    tag_data [1:mem_config_pkg::NUM_MEM_TAGS]
);

    import mem_types_pkg::*;
    import mem_config_pkg::*;

    // per-tag state
    logic [LATENCY_COUNT_BITS-1:0] count [1:NUM_MEM_TAGS];
    logic [NUM_MEM_TAGS:1]         waiting;
    logic [NUM_MEM_TAGS:1]         free_vector;

    // allocation
    mem_tag_t alloc_tag;
    logic     take_tag;

    //////////////////////////////
    // tag status
    //////////////////////////////

    always_comb begin
        for (int i = 1; i <= NUM_MEM_TAGS; i++) begin
            // idle and not holding data for the bus
            free_vector[i] = (count[i] == '0) && !waiting[i];
            // count hits zero at this edge or already sits there
            ready_vector[i] = waiting[i] && (count[i] <= LATENCY_COUNT_BITS'(1));
        end
    end

    // lowest free tag wins, 0 when the table is full
    always_comb begin
        alloc_tag = '0;
        for (int i = NUM_MEM_TAGS; i >= 1; i--) begin
            if (free_vector[i]) begin
                alloc_tag = mem_tag_t'(i);
            end
        end
    end

    assign take_tag = accept_request && (alloc_tag != '0);

    //////////////////////////////
    // countdown and flags
    //////////////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            transaction_tag <= '0;
            waiting         <= '0;
            for (int i = 1; i <= NUM_MEM_TAGS; i++) begin
                count[i] <= '0;
            end
        end else begin
            // one-cycle answer, refused requests see 0
            transaction_tag <= take_tag ? alloc_tag : '0;
            for (int i = 1; i <= NUM_MEM_TAGS; i++) begin
                if (count[i] != '0) begin
                    count[i] <= count[i] - 1'b1;
                end else if (take_tag && (alloc_tag == mem_tag_t'(i))) begin
                    count[i] <= LATENCY_COUNT_BITS'(MEM_LATENCY);
                    // stores only hold the tag for the countdown
                    waiting[i] <= do_load;
                end
                // result bus took this tag
                if (grant_vector[i]) begin
                    waiting[i] <= 1'b0;
                end
            end
        end
    end

    //////////////////////////////
    // load data slots
    //////////////////////////////

    // block read at the request edge, held until the grant
    always_ff @(posedge clock) begin
        for (int i = 1; i <= NUM_MEM_TAGS; i++) begin
            if (take_tag && do_load && (alloc_tag == mem_tag_t'(i))) begin
                tag_data[i] <= read_block;
            end
        end
    end

endmodule

`default_nettype wire

/* src/mem_response_arbiter.sv */
// result stage arbiter
// fixed priority pick of the lowest ready tag, registered result bus

`timescale 1ns/10ps
`default_nettype none

module mem_response_arbiter (
    input  wire logic                                  clock,
    input  wire logic                                  arst_n,
    input  wire logic [mem_config_pkg::NUM_MEM_TAGS:1] ready_vector,
    input  wire mem_types_pkg::mem_block_t             tag_data [1:mem_config_pkg::NUM_MEM_TAGS],
    output logic [mem_config_pkg::NUM_MEM_TAGS:1]      grant_vector,
    output mem_types_pkg::mem_tag_t                    data_tag,
    output mem_types_pkg::mem_block_t                  data_block
);

    import mem_types_pkg::*;
    import mem_config_pkg::*;

    mem_tag_t   pick_tag;
    mem_block_t pick_block;

    // scan down so the lowest ready tag is left standing
    always_comb begin
        pick_tag   = '0;
        pick_block = '0;
        for (int i = NUM_MEM_TAGS; i >= 1; i--) begin
            if (ready_vector[i]) begin
                pick_tag   = mem_tag_t'(i);
                pick_block = tag_data[i];
            end
        end
    end

    // one-hot grant back to the table, none when idle
    always_comb begin
        for (int i = 1; i <= NUM_MEM_TAGS; i++) begin
            grant_vector[i] = (pick_tag == mem_tag_t'(i));
        end
    end

    //////////////////////////////
    // result bus
    //////////////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            data_tag   <= '0;
            data_block <= '0;
        end else begin
            data_tag   <= pick_tag;
            data_block <= pick_block;
        end
    end

endmodule

`default_nettype wire

/* src/mem_model.sv */
// pipelined memory model top
// decode, storage, tag table and result arbiter

`timescale 1ns/10ps
`default_nettype none

module mem_model (
    input  wire logic                      clock,
    input  wire logic                      arst_n,
    input  wire mem_types_pkg::mem_addr_t  proc2mem_addr,
    input  wire mem_types_pkg::mem_block_t proc2mem_data,
    input  wire mem_types_pkg::mem_cmd_e   proc2mem_command,
    output mem_types_pkg::mem_tag_t        mem2proc_transaction_tag,
    output mem_types_pkg::mem_block_t      mem2proc_data,
    output mem_types_pkg::mem_tag_t        mem2proc_data_tag
);

    import mem_types_pkg::*;
    import mem_config_pkg::*;

    // decode outputs
    logic [LINE_INDEX_BITS-1:0] line_index;
    logic                       do_load;
    logic                       do_store;
    logic                       accept_request;

    // storage to tag table
    mem_block_t read_block;

    // tag table and arbiter handshake
    logic [NUM_MEM_TAGS:1] ready_vector;
    logic [NUM_MEM_TAGS:1] grant_vector;
    mem_block_t            tag_data [1:NUM_MEM_TAGS];

    mem_request_decode u_decode (
        .proc2mem_addr    (proc2mem_addr),
        .proc2mem_command (proc2mem_command),
        .line_index       (line_index),
        .do_load          (do_load),
        .do_store         (do_store),
        .accept_request   (accept_request)
    );

    mem_array u_array (
        .clock       (clock),
        .line_index  (line_index),
        .do_store    (do_store),
        .write_block (proc2mem_data),
        .read_block  (read_block)
    );

    mem_tag_table u_tag_table (
        .clock           (clock),
        .arst_n          (arst_n),
        .accept_request  (accept_request),
        .do_load         (do_load),
        .read_block      (read_block),
        .grant_vector    (grant_vector),
        .transaction_tag (mem2proc_transaction_tag),
        .ready_vector    (ready_vector),
        .tag_data        (tag_data)
    );

    mem_response_arbiter u_arbiter (
        .clock        (clock),
        .arst_n       (arst_n),
        .ready_vector (ready_vector),
        .tag_data     (tag_data),
        .grant_vector (grant_vector),
        .data_tag     (mem2proc_data_tag),
        .data_block   (mem2proc_data)
    );

endmodule

`default_nettype wire

/* bench/mem_model_sva.sv */
// bound port checks for the memory model
// tag order, data tags already issued, tags cleared by reset

`timescale 1ns/10ps
`default_nettype none

module mem_model_sva (
    input wire logic                    clock,
    input wire logic                    arst_n,
    input wire mem_types_pkg::mem_tag_t mem2proc_transaction_tag,
    input wire mem_types_pkg::mem_tag_t mem2proc_data_tag
);

    import mem_types_pkg::*;
    import mem_config_pkg::*;

    // sticky record of every tag handed out
    logic [NUM_MEM_TAGS:0] issued;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            issued <= '0;
        end else if (mem2proc_transaction_tag != '0) begin
            issued[mem2proc_transaction_tag] <= 1'b1;
        end
    end

    // lowest free tag first, so tag n needs tag n-1 handed out before it
    tag_lowest_first: assert property (@(posedge clock) disable iff (!arst_n)
        (mem2proc_transaction_tag <= mem_tag_t'(1)) ||
        issued[mem2proc_transaction_tag - 1'b1])
        else $error("transaction tag issued ahead of a lower tag");

    data_tag_issued: assert property (@(posedge clock) disable iff (!arst_n)
        (mem2proc_data_tag == '0) || issued[mem2proc_data_tag])
        else $error("data tag never issued as a transaction tag");

    // first edge out of reset still shows the reset values
    tags_clear_after_reset: assert property (@(posedge clock)
        $rose(arst_n) |-> (mem2proc_transaction_tag == '0) && (mem2proc_data_tag == '0))
        else $error("tags not zero after reset");

endmodule

bind mem_model mem_model_sva u_sva (
    .clock                    (clock),
    .arst_n                   (arst_n),
    .mem2proc_transaction_tag (mem2proc_transaction_tag),
    .mem2proc_data_tag        (mem2proc_data_tag)
);

`default_nettype wire

/* bench/mem_model_tb.sv */
// testbench for the pipelined memory model
// lfsr stimulus, shadow memory, tag scoreboard and compare tasks

`timescale 1ns/10ps
`default_nettype none

module mem_model_tb;

    import mem_types_pkg::*;
    import mem_config_pkg::*;

    localparam int unsigned POOL_SIZE   = 16;
    localparam int unsigned DRAIN_LIMIT = 100;

    logic       clock;
    logic       arst_n;
    mem_addr_t  proc2mem_addr;
    mem_block_t proc2mem_data;
    mem_cmd_e   proc2mem_command;
    mem_tag_t   mem2proc_transaction_tag;
    mem_block_t mem2proc_data;
    mem_tag_t   mem2proc_data_tag;

    logic [31:0] lfsr_state  = 32'hc59146b7;
    int unsigned error_count = 0;
    int unsigned cycle_count = 0;
    logic        latency_check_on = 1'b0;

    // scoreboard, slot 0 unused
    logic        busy [0:NUM_MEM_TAGS] = '{default: 1'b0};
    logic        is_load [0:NUM_MEM_TAGS] = '{default: 1'b0};
    int unsigned issue_cycle [0:NUM_MEM_TAGS] = '{default: 0};
    mem_block_t  expected_data [0:NUM_MEM_TAGS];

    // expected memory contents and the request awaiting its tag
    mem_block_t shadow [MEM_LINES];
    mem_cmd_e   pend_cmd   = MEM_NONE;
    mem_addr_t  pend_addr  = '0;
    mem_block_t pend_block = '0;

    mem_model u_dut (
        .clock                    (clock),
        .arst_n                   (arst_n),
        .proc2mem_addr            (proc2mem_addr),
        .proc2mem_data            (proc2mem_data),
        .proc2mem_command         (proc2mem_command),
        .mem2proc_transaction_tag (mem2proc_transaction_tag),
        .mem2proc_data            (mem2proc_data),
        .mem2proc_data_tag        (mem2proc_data_tag)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    //////////////////////////////
    // reference and helpers
    //////////////////////////////

    // aligned, in range, load or store, and a tag left
    function automatic logic expected_accept_ok(mem_addr_t addr, mem_cmd_e cmd,
                                                int unsigned tags_held);
        logic addr_ok;
        addr_ok = (addr[2:0] == 3'b000) && (addr < MEM_SIZE_IN_BYTES);
        return addr_ok && (cmd == MEM_LOAD || cmd == MEM_STORE) && (tags_held < NUM_MEM_TAGS);
    endfunction

    function automatic int unsigned tags_in_use();
        int unsigned n;
        n = 0;
        for (int i = 1; i <= NUM_MEM_TAGS; i++) begin
            n += busy[i];
        end
        return n;
    endfunction

    // tags are handed out lowest first
    function automatic mem_tag_t lowest_free_tag();
        for (int i = 1; i <= NUM_MEM_TAGS; i++) begin
            if (!busy[i]) begin
                return mem_tag_t'(i);
            end
        end
        return '0;
    endfunction

    // fibonacci lfsr, x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] random_bits(int unsigned count);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < count; i++) begin
            feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], feedback};
            value      = {value[30:0], feedback};
        end
        return value;
    endfunction

    // scattered lines that the setup phase fills
    function automatic mem_addr_t pool_addr(int unsigned k);
        return mem_addr_t'(((k * 37 + 5) % MEM_LINES) * 8);
    endfunction

    task automatic report_failure(string msg);
        $display("%s", msg);
        error_count++;
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_tag(string name, mem_tag_t actual, mem_tag_t expected);
        if (actual !== expected) begin
            report_failure($sformatf("Error at %0t: %s = %0d, expected %0d",
                                     $time, name, actual, expected));
        end
    endtask

    task automatic check_block(string name, mem_block_t actual, mem_block_t expected);
        if (actual !== expected) begin
            report_failure($sformatf("Error at %0t: %s = %h, expected %h",
                                     $time, name, actual, expected));
        end
    endtask

    task automatic check_latency(string name, int unsigned actual, int unsigned expected);
        if (actual != expected) begin
            report_failure($sformatf("Error at %0t: %s latency = %0d, expected %0d",
                                     $time, name, actual, expected));
        end
    endtask

    //////////////////////////////
    // scoreboard
    //////////////////////////////

    // outputs sampled mid-cycle, away from the driving edge
    always @(negedge clock) begin : compare_outputs
        mem_tag_t    got_tag;
        mem_tag_t    exp_tag;
        mem_tag_t    ret_tag;
        int unsigned line;
        if (arst_n) begin
            cycle_count++;
            got_tag = mem2proc_transaction_tag;
            exp_tag = '0;
            if (expected_accept_ok(pend_addr, pend_cmd, tags_in_use())) begin
                exp_tag = lowest_free_tag();
            end
            if (got_tag != '0 && busy[got_tag]) begin
                report_failure("transaction tag issued while still outstanding");
            end
            check_tag("mem2proc_transaction_tag", got_tag, exp_tag);
            // result bus, loads only and once per tag
            ret_tag = mem2proc_data_tag;
            if (ret_tag != '0) begin
                if (!busy[ret_tag] || !is_load[ret_tag]) begin
                    report_failure("data bus transfer for a tag with no outstanding load");
                end
                check_block("mem2proc_data", mem2proc_data, expected_data[ret_tag]);
                if (latency_check_on) begin
                    check_latency("mem2proc_data_tag", cycle_count - issue_cycle[ret_tag],
                                  MEM_LATENCY);
                end
                busy[ret_tag] = 1'b0;
            end
            // stores give their tag back after the countdown
            for (int i = 1; i <= NUM_MEM_TAGS; i++) begin
                if (busy[i] && !is_load[i] && cycle_count - issue_cycle[i] >= MEM_LATENCY) begin
                    busy[i] = 1'b0;
                end
            end
            if (got_tag != '0) begin
                busy[got_tag]          = 1'b1;
                is_load[got_tag]       = (pend_cmd == MEM_LOAD);
                issue_cycle[got_tag]   = cycle_count;
                expected_data[got_tag] = pend_block;
            end
        end
        // request the dut samples at the next edge
        pend_cmd  = proc2mem_command;
        pend_addr = proc2mem_addr;
        if (expected_accept_ok(proc2mem_addr, proc2mem_command, 0)) begin
            line = proc2mem_addr >> 3;
            if (proc2mem_command == MEM_LOAD) begin
                pend_block = shadow[line];
            end else begin
                shadow[line] = proc2mem_data;
            end
        end
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////

    task automatic send_request(mem_cmd_e cmd, mem_addr_t addr, mem_block_t data);
        @(posedge clock);
        proc2mem_command <= cmd;
        proc2mem_addr    <= addr;
        proc2mem_data    <= data;
    endtask

    task automatic send_idle();
        send_request(MEM_NONE, '0, '0);
    endtask

    // mix of loads, stores, idles, unaligned and out of range
    task automatic send_random_request();
        logic [2:0] pick;
        logic [2:0] where;
        mem_addr_t  addr;
        mem_cmd_e   cmd;
        pick  = random_bits(3);
        where = random_bits(3);
        addr  = pool_addr(random_bits(4));
        if (pick == 3'd0 || pick == 3'd7) begin
            cmd = MEM_NONE;
        end else if (pick <= 3'd4) begin
            cmd = MEM_LOAD;
        end else begin
            cmd = MEM_STORE;
        end
        if (where == 3'd0) begin
            addr[2:0] = 3'(random_bits(2)) + 3'd1;
        end else if (where == 3'd1) begin
            addr = mem_addr_t'(MEM_SIZE_IN_BYTES) + (random_bits(20) << 3);
        end
        send_request(cmd, addr, {random_bits(32), random_bits(32)});
    endtask

    task automatic wait_drained();
        int unsigned waited;
        waited = 0;
        @(posedge clock);
        while (tags_in_use() != 0) begin
            if (waited == DRAIN_LIMIT) begin
                report_failure("timeout waiting for outstanding tags to return");
            end
            waited++;
            @(posedge clock);
        end
    endtask

    initial begin : run_test
        proc2mem_command = MEM_NONE;
        proc2mem_addr    = '0;
        proc2mem_data    = '0;
        arst_n           = 1'b0;
        repeat (4) @(posedge clock);
        arst_n <= 1'b1;
        // setup, fill every line that is loaded later
        for (int k = 0; k < POOL_SIZE; k++) begin
            send_request(MEM_STORE, pool_addr(k), {random_bits(32), random_bits(32)});
        end
        send_idle();
        wait_drained();
        // one load alone on the bus
        latency_check_on <= 1'b1;
        send_request(MEM_LOAD, pool_addr(5), '0);
        send_idle();
        wait_drained();
        latency_check_on <= 1'b0;
        // load, then overwrite the same line while it is in flight
        send_request(MEM_LOAD, pool_addr(3), '0);
        send_request(MEM_STORE, pool_addr(3), {random_bits(32), random_bits(32)});
        send_request(MEM_LOAD, pool_addr(3), '0);
        send_idle();
        wait_drained();
        // 16 loads back to back, the oldest tags return before the table fills
        for (int k = 0; k < 16; k++) begin
            send_request(MEM_LOAD, pool_addr(k), '0);
        end
        send_idle();
        wait_drained();
        send_request(MEM_LOAD, pool_addr(0), '0);
        send_idle();
        wait_drained();
        // random traffic
        for (int n = 0; n < 400; n++) begin
            send_random_request();
        end
        send_idle();
        wait_drained();
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* mem_model.f */
src/mem_types_pkg.sv
src/mem_config_pkg.sv
src/mem_request_decode.sv
src/mem_array.sv
src/mem_tag_table.sv
src/mem_response_arbiter.sv
src/mem_model.sv
bench/mem_model_sva.sv
bench/mem_model_tb.sv

/* Bender.yml */
package:
  name: mem_model

sources:
  - src/mem_types_pkg.sv
  - src/mem_config_pkg.sv
  - src/mem_request_decode.sv
  - src/mem_array.sv
  - src/mem_tag_table.sv
  - src/mem_response_arbiter.sv
  - src/mem_model.sv
  - target: test
    files:
      - bench/mem_model_sva.sv
      - bench/mem_model_tb.sv
